// File: sqrArithPkg.sv
package sqrArithPkg;

   localparam int limbW     = 16;
   localparam int numLimbs  = 4;
   localparam int chunkW    = 8;
   localparam int numChunks = 8;
   localparam int opW       = 64;

   typedef logic [limbW-1:0]     limbT;
   typedef logic [opW-1:0]       operandT;
   typedef logic [2*opW-1:0]     productT;
   typedef logic [2*limbW-1:0]   partialT;
   typedef logic [opW-1:0]       residueT;
   typedef logic [opW:0]         foldSumT;

   // entry row*numLimbs + col holds limb[row] * limb[col].
   typedef partialT [numLimbs*numLimbs-1:0] partialArrayT;
   typedef residueT [numChunks-1:0]         residueVecT;

   // 2^60 - 93.
   localparam operandT modulus = 64'h0FFF_FFFF_FFFF_FFA3;

   // chunk * 2^e mod M, by repeated doubling.
   // values stay below M < 2^60, so one subtraction per step is enough.
   function automatic residueT residueOf(input int unsigned chunk, input int unsigned e);
      logic [opW:0] acc;
      acc = chunk % modulus;
      for (int unsigned i = 0; i < e; i++)
      begin
         acc = acc << 1;
         if (acc >= modulus)
         begin
            acc = acc - modulus;
         end
      end
      return acc[opW-1:0];
   endfunction

   // added back once when the fold sum carries past bit 63.
   localparam residueT overflowResidue = residueOf(1, opW);

endpackage

// File: sqrCtrlPkg.sv
package sqrCtrlPkg;

   // one iteration walks Multiply through Writeback and starts over.
   typedef enum logic [2:0]
   {
      Idle,
      Multiply,
      Accumulate,
      Lookup,
      Fold,
      FoldExtra,
      Writeback
   } sqrStateT;

   // each datapath stage loads its register only when its own bit is set.
   typedef struct packed
   {
      logic loadOp;
      logic capPartial;
      logic capColumn;
      logic capLookup;
      logic capFold;
      logic capExtra;
      logic writeOp;
   } phaseCtrlT;

endpackage

// File: partialProductArray.sv
`timescale 1ns/1ps

module partialProductArray
(
   input  logic                      clk_sq,
   input  sqrCtrlPkg::phaseCtrlT     phase,
   input  sqrArithPkg::operandT      operand,
   output sqrArithPkg::partialArrayT partials
);

   sqrArithPkg::limbT         limbs [sqrArithPkg::numLimbs];
   sqrArithPkg::partialArrayT partialsNext;

   always_comb
   begin
      for (int l = 0; l < sqrArithPkg::numLimbs; l++)
      begin
         limbs[l] = operand[l*sqrArithPkg::limbW +: sqrArithPkg::limbW];
      end
   end

   // the full square matrix is formed, mirror terms included.
   // the 32-bit target widens both limbs before the multiply.
   always_comb
   begin
      for (int r = 0; r < sqrArithPkg::numLimbs; r++)
      begin
         for (int c = 0; c < sqrArithPkg::numLimbs; c++)
         begin
            partialsNext[r*sqrArithPkg::numLimbs + c] = limbs[r] * limbs[c];
         end
      end
   end

   always_ff @(posedge clk_sq)
   begin
      if (phase.capPartial)
      begin
         partials <= partialsNext;
      end
   end

endmodule

// File: columnAccumulator.sv
`timescale 1ns/1ps

module columnAccumulator
(
   input  logic                      clk_sq,
   input  sqrCtrlPkg::phaseCtrlT     phase,
   input  sqrArithPkg::partialArrayT partials,
   output sqrArithPkg::productT      product
);

   // a column gathers at most seven 16-bit terms, so four guard bits hold it.
   logic [2*sqrArithPkg::numLimbs-1:0][sqrArithPkg::limbW+3:0] colSum;
   logic [sqrArithPkg::limbW+3:0] colAcc;
   logic [3:0]                    colCarry;
   sqrArithPkg::productT          productNext;

   always_comb
   begin
      colSum = '0;
      for (int r = 0; r < sqrArithPkg::numLimbs; r++)
      begin
         for (int c = 0; c < sqrArithPkg::numLimbs; c++)
         begin
            // low limb lands in column r+c, high limb one column up.
            colSum[r+c] += partials[r*sqrArithPkg::numLimbs + c][sqrArithPkg::limbW-1:0];
            colSum[r+c+1] += partials[r*sqrArithPkg::numLimbs + c]
                             [2*sqrArithPkg::limbW-1:sqrArithPkg::limbW];
         end
      end
   end

   // ripple the column overflow upward, one limb at a time.
   always_comb
   begin
      colCarry = '0;
      colAcc = '0;
      productNext = '0;
      for (int k = 0; k < 2*sqrArithPkg::numLimbs; k++)
      begin
         colAcc = colSum[k] + colCarry;
         productNext[k*sqrArithPkg::limbW +: sqrArithPkg::limbW] =
            colAcc[sqrArithPkg::limbW-1:0];
         colCarry = colAcc[sqrArithPkg::limbW+3:sqrArithPkg::limbW];
      end
   end

   always_ff @(posedge clk_sq)
   begin
      if (phase.capColumn)
      begin
         product <= productNext;
      end
   end

endmodule

// File: foldTable.sv
`timescale 1ns/1ps

module foldTable
(
   input  logic                    clk_sq,
   input  sqrCtrlPkg::phaseCtrlT   phase,
   input  sqrArithPkg::operandT    highHalf,
   output sqrArithPkg::residueVecT residues
);

   sqrArithPkg::residueVecT lookupRes;

   // chunk p of the high half carries weight 2^(64 + 8p).
   // each position gets its own ROM of residues for that weight.
   for (genvar p = 0; p < sqrArithPkg::numChunks; p++)
   begin : chunkGen
      sqrArithPkg::residueT lut [2**sqrArithPkg::chunkW];

      for (genvar v = 0; v < 2**sqrArithPkg::chunkW; v++)
      begin : entryGen
         assign lut[v] = sqrArithPkg::residueOf(v, sqrArithPkg::opW + sqrArithPkg::chunkW*p);
      end

      assign lookupRes[p] = lut[highHalf[p*sqrArithPkg::chunkW +: sqrArithPkg::chunkW]];
   end

   always_ff @(posedge clk_sq)
   begin
      if (phase.capLookup)
      begin
         residues <= lookupRes;
      end
   end

endmodule

// File: foldReducer.sv
`timescale 1ns/1ps

module foldReducer
(
   input  logic                    clk_sq,
   input  sqrCtrlPkg::phaseCtrlT   phase,
   input  sqrArithPkg::operandT    lowHalf,
   input  sqrArithPkg::residueVecT residues,
   output sqrArithPkg::operandT    folded,
   output logic                    foldOverflow
);

   sqrArithPkg::foldSumT foldSum;
   sqrArithPkg::foldSumT sumNext;
   sqrArithPkg::foldSumT extraNext;

   // the low half is below 2^64 and each residue below 2^60.
   // so the total stays under 2^64 + 2^63 and fits in 65 bits.
   always_comb
   begin
      sumNext = {1'b0, lowHalf};
      for (int p = 0; p < sqrArithPkg::numChunks; p++)
      begin
         sumNext = sumNext + {1'b0, residues[p]};
      end
   end

   // after an overflow the low 64 bits are under 2^63.
   // adding 2^64 mod M then cannot carry out again.
   assign extraNext = {1'b0, foldSum[sqrArithPkg::opW-1:0]}
                      + {1'b0, sqrArithPkg::overflowResidue};

   always_ff @(posedge clk_sq)
   begin
      if (phase.capFold)
      begin
         foldSum <= sumNext;
      end
      else if (phase.capExtra)
      begin
         foldSum <= extraNext;
      end
   end

   assign folded       = foldSum[sqrArithPkg::opW-1:0];
   assign foldOverflow = foldSum[sqrArithPkg::opW];

endmodule

// File: operandReg.sv
`timescale 1ns/1ps

module operandReg
(
   input  logic                  clk_sq,
   input  sqrCtrlPkg::phaseCtrlT phase,
   input  sqrArithPkg::operandT  sqIn,
   input  sqrArithPkg::operandT  folded,
   output sqrArithPkg::operandT  operand
);

   // a fresh chain loads sqIn, every iteration after that feeds back the folded square.
   always_ff @(posedge clk_sq)
   begin
      if (phase.loadOp)
      begin
         operand <= sqIn;
      end
      else if (phase.writeOp)
      begin
         operand <= folded;
      end
   end

endmodule

// File: sqrSequencer.sv
`timescale 1ns/1ps

module sqrSequencer
(
   input  logic                  clk_sq,
   input  logic                  reset_sq,
   input  logic                  start,
   input  logic                  foldOverflow,
   output sqrCtrlPkg::phaseCtrlT phase,
   output logic                  doneIter
);

   sqrCtrlPkg::sqrStateT state;
   sqrCtrlPkg::sqrStateT nextState;

   always_ff @(posedge clk_sq)
   begin
      if (reset_sq)
      begin
         state    <= sqrCtrlPkg::Idle;
         doneIter <= 1'b0;
      end
      else
      begin
         state    <= nextState;
         doneIter <= (state == sqrCtrlPkg::Writeback);
      end
   end

   // the fold sum is registered at the end of Fold.
   // its carry bit is first visible in FoldExtra, so the extra fold is decided there.
   always_comb
   begin
      nextState = state;
      case (state)
         sqrCtrlPkg::Idle:
         begin
            if (start)
            begin
               nextState = sqrCtrlPkg::Multiply;
            end
         end
         sqrCtrlPkg::Multiply:   nextState = sqrCtrlPkg::Accumulate;
         sqrCtrlPkg::Accumulate: nextState = sqrCtrlPkg::Lookup;
         sqrCtrlPkg::Lookup:     nextState = sqrCtrlPkg::Fold;
         sqrCtrlPkg::Fold:       nextState = sqrCtrlPkg::FoldExtra;
         sqrCtrlPkg::FoldExtra:  nextState = sqrCtrlPkg::Writeback;
         sqrCtrlPkg::Writeback:  nextState = sqrCtrlPkg::Multiply;
         default:                nextState = sqrCtrlPkg::Idle;
      endcase
   end

   always_comb
   begin
      phase            = '0;
      phase.loadOp     = (state == sqrCtrlPkg::Idle) && start;
      phase.capPartial = (state == sqrCtrlPkg::Multiply);
      phase.capColumn  = (state == sqrCtrlPkg::Accumulate);
      phase.capLookup  = (state == sqrCtrlPkg::Lookup);
      phase.capFold    = (state == sqrCtrlPkg::Fold);
      phase.capExtra   = (state == sqrCtrlPkg::FoldExtra) && foldOverflow;
      phase.writeOp    = (state == sqrCtrlPkg::Writeback);
   end

endmodule

// File: sqrTop.sv
`timescale 1ns/1ps

module sqrTop
(
   input  logic                 clk_sq,
   input  logic                 reset_sq,
   input  logic                 start,
   input  sqrArithPkg::operandT sqIn,
   output sqrArithPkg::operandT sqOut,
   output logic                 doneIter
);

   sqrCtrlPkg::phaseCtrlT     phase;
   sqrArithPkg::partialArrayT partials;
   sqrArithPkg::productT      product;
   sqrArithPkg::residueVecT   residues;
   sqrArithPkg::operandT      folded;
   logic                      foldOverflow;

   // the operand register output is both the squarer input and sqOut.
   operandReg iOperandReg
   (
      .clk_sq  (clk_sq),
      .phase   (phase),
      .sqIn    (sqIn),
      .folded  (folded),
      .operand (sqOut)
   );

   partialProductArray iPartialProductArray
   (
      .clk_sq   (clk_sq),
      .phase    (phase),
      .operand  (sqOut),
      .partials (partials)
   );

   columnAccumulator iColumnAccumulator
   (
      .clk_sq   (clk_sq),
      .phase    (phase),
      .partials (partials),
      .product  (product)
   );

   foldTable iFoldTable
   (
      .clk_sq   (clk_sq),
      .phase    (phase),
      .highHalf (product[2*sqrArithPkg::opW-1:sqrArithPkg::opW]),
      .residues (residues)
   );

   foldReducer iFoldReducer
   (
      .clk_sq       (clk_sq),
      .phase        (phase),
      .lowHalf      (product[sqrArithPkg::opW-1:0]),
      .residues     (residues),
      .folded       (folded),
      .foldOverflow (foldOverflow)
   );

   sqrSequencer iSqrSequencer
   (
      .clk_sq       (clk_sq),
      .reset_sq     (reset_sq),
      .start        (start),
      .foldOverflow (foldOverflow),
      .phase        (phase),
      .doneIter     (doneIter)
   );

endmodule

// File: clockGen.sv
`timescale 1ns/1ps

module clockGen
(
   output logic clk_sq
);

   // 4 ns period, starting low.
   initial
   begin
      clk_sq = 1'b0;
   end

   always
   begin
      #2 clk_sq = ~clk_sq;
   end

endmodule

// File: sqrTop_tb.sv
`timescale 1ns/1ps

module sqrTop_tb;

   // the modulus 2^60 - 93 is widened so that the model can square without overflow.
   localparam logic [127:0] modRef      = (128'd1 << 60) - 128'd93;
   localparam int           numRows     = 7;
   localparam int           quietCycles = 10;
   localparam int           decoyLen    = 7;
   localparam logic [63:0]  freshMask   = 64'h5A5A_C3C3_0F0F_9696;

   // decoyAt and resetAt count cycles after start is seen. A value of zero leaves it unused.
   typedef struct packed
   {
      logic [63:0] operand;
      int          iters;
      int          decoyAt;
      int          resetAt;
   } testRowT;

   logic                 clk_sq;
   logic                 reset_sq;
   logic                 start;
   sqrArithPkg::operandT sqIn;
   sqrArithPkg::operandT sqOut;
   logic                 doneIter;

   testRowT rows [numRows];
   int      seed;
   int      cycleCount = 0;
   int      cycleLimit = 0;

   clockGen iClockGen
   (
      .clk_sq (clk_sq)
   );

   sqrTop i_dut
   (
      .clk_sq   (clk_sq),
      .reset_sq (reset_sq),
      .start    (start),
      .sqIn     (sqIn),
      .sqOut    (sqOut),
      .doneIter (doneIter)
   );

   // reference square, with the operand already below the modulus.
   function automatic logic [127:0] squareMod(input logic [127:0] x);
      return (x * x) % modRef;
   endfunction

   task automatic checkEqual(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
      if (actual !== expected)
      begin
         $display("Error: at %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
         $display("SIMULATION FAILED");
         $fatal(1);
      end
   endtask

   task automatic applyReset();
      @(posedge clk_sq);
      reset_sq <= 1'b1;
      start    <= 1'b0;
      repeat (3)
      begin
         @(posedge clk_sq);
      end
      reset_sq <= 1'b0;
   endtask

   task automatic expectQuiet(input int cycles, input string what);
      repeat (cycles)
      begin
         @(negedge clk_sq);
         checkEqual(doneIter, 1'b0, what);
      end
   endtask

   // starts a chain from op and checks every doneIter pulse.
   // a nonzero stopAt leaves the chain at that cycle for a reset.
   task automatic runChain(input logic [63:0] op, input int iters, input int decoyAt,
                           input int stopAt, input string tag);
      logic [127:0] expected;
      int           k;
      int           sinceStart;
      int           lastPulse;
      bit           gapOk;
      expected   = {64'd0, op} % modRef;
      k          = 0;
      sinceStart = 0;
      lastPulse  = 0;
      @(posedge clk_sq);
      start <= 1'b1;
      sqIn  <= op;
      @(posedge clk_sq);
      start <= 1'b0;
      while (k < iters && !(stopAt > 0 && sinceStart >= stopAt))
      begin
         @(negedge clk_sq);
         if (doneIter)
         begin
            k++;
            expected = squareMod(expected);
            gapOk = (sinceStart - lastPulse == 6) || (sinceStart - lastPulse == 7);
            checkEqual(gapOk, 1'b1, $sformatf("%s: spacing of %0d cycles before doneIter %0d",
                                              tag, sinceStart - lastPulse, k));
            checkEqual({64'd0, sqOut} % modRef, expected,
                       $sformatf("%s: sqOut mod M after doneIter %0d", tag, k));
            lastPulse = sinceStart;
         end
         if (k < iters)
         begin
            @(posedge clk_sq);
            sinceStart++;
            // a second start inside the chain must be ignored.
            // it stays high for a whole iteration so that it overlaps Writeback too.
            if (decoyAt > 0 && sinceStart == decoyAt)
            begin
               start <= 1'b1;
               sqIn  <= ~op;
            end
            else if (decoyAt > 0 && sinceStart == decoyAt + decoyLen)
            begin
               start <= 1'b0;
            end
         end
      end
   endtask

   always @(posedge clk_sq)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleLimit > 0 && cycleCount > cycleLimit)
      begin
         $display("Timeout: the run went past %0d clock cycles without finishing.", cycleLimit);
         $display("SIMULATION FAILED");
         $fatal(1);
      end
   end

   initial
   begin
      reset_sq = 1'b1;
      start    = 1'b0;
      sqIn     = '0;
      seed     = 75;

      rows[0] = '{64'h0000_0000_0000_0003, 10, 0, 0};
      rows[1] = '{64'hFFFF_FFFF_FFFF_FFFF, 10, 0, 0};
      rows[2] = '{64'hFFFF_FFFF_FFFF_FF00, 9, 0, 0};
      rows[3] = '{64'h0123_4567_89AB_CDEF, 12, 20, 0};
      rows[4] = '{64'hFEDC_BA98_7654_3210, 10, 0, 15};
      rows[5] = '{{$random(seed), $random(seed)}, 8, 0, 0};
      rows[6] = '{{$random(seed), $random(seed)}, 11, 0, 0};

      // the limit allows 7 cycles per iteration and 20 per row plus the reset detour
      // and the idle check.
      cycleLimit = 40;
      for (int i = 0; i < numRows; i++)
      begin
         cycleLimit += 7 * rows[i].iters + 20;
         if (rows[i].resetAt > 0)
         begin
            cycleLimit += rows[i].resetAt + quietCycles + 10;
         end
      end

      repeat (3)
      begin
         @(posedge clk_sq);
      end
      reset_sq <= 1'b0;
      expectQuiet(20, "doneIter while idle after reset");

      for (int i = 0; i < numRows; i++)
      begin
         applyReset();
         runChain(rows[i].operand, rows[i].iters, rows[i].decoyAt, rows[i].resetAt,
                  $sformatf("row %0d", i));
         if (rows[i].resetAt > 0)
         begin
            applyReset();
            expectQuiet(quietCycles, $sformatf("row %0d: doneIter after mid-chain reset", i));
            runChain(rows[i].operand ^ freshMask, rows[i].iters, 0, 0,
                     $sformatf("row %0d after reset", i));
         end
      end

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// File: sqrTop.f
sqrArithPkg.sv
sqrCtrlPkg.sv
partialProductArray.sv
columnAccumulator.sv
foldTable.sv
foldReducer.sv
operandReg.sv
sqrSequencer.sv
sqrTop.sv
clockGen.sv
sqrTop_tb.sv

// File: runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module sqrTop_tb -f sqrTop.f -o sqrTopSim
./obj_dir/sqrTopSim > sim.log 2>&1 || true
cat sim.log
if grep -q "SIMULATION PASSED" sim.log
then
   echo "run passed"
   exit 0
fi
echo "run failed"
exit 1
